/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = control_unit_tb
FILE_LIST  = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulation exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/decode_pkg.sv */
package decode_pkg;

        localparam int INSTR_W  = 32;
        localparam int OPCODE_W = 6;
        localparam int FUNCT_W  = 6;

        // primary opcodes, instruction[31:26]
        localparam logic [OPCODE_W-1:0] R_TYPE_OP = 6'b000000;
        localparam logic [OPCODE_W-1:0] BGEZ_OP   = 6'b000001; // regimm group
        localparam logic [OPCODE_W-1:0] JAL_OP    = 6'b000011;
        localparam logic [OPCODE_W-1:0] B_OP      = 6'b000100; // beq slot
        localparam logic [OPCODE_W-1:0] BGTZ_OP   = 6'b000111;
        localparam logic [OPCODE_W-1:0] ADDI_OP   = 6'b001000;
        localparam logic [OPCODE_W-1:0] ADDIU_OP  = 6'b001001;
        localparam logic [OPCODE_W-1:0] SLTI_OP   = 6'b001010;
        localparam logic [OPCODE_W-1:0] ANDI_OP   = 6'b001100;
        localparam logic [OPCODE_W-1:0] ORI_OP    = 6'b001101;
        localparam logic [OPCODE_W-1:0] XORI_OP   = 6'b001110;
        localparam logic [OPCODE_W-1:0] LUI_OP    = 6'b001111;
        localparam logic [OPCODE_W-1:0] LB_OP     = 6'b100000;
        localparam logic [OPCODE_W-1:0] LH_OP     = 6'b100001;
        localparam logic [OPCODE_W-1:0] LW_OP     = 6'b100011;
        localparam logic [OPCODE_W-1:0] LBU_OP    = 6'b100100;
        localparam logic [OPCODE_W-1:0] LHU_OP    = 6'b100101;
        localparam logic [OPCODE_W-1:0] SB_OP     = 6'b101000;
        localparam logic [OPCODE_W-1:0] SH_OP     = 6'b101001;
        localparam logic [OPCODE_W-1:0] SW_OP     = 6'b101011;

        // function codes for R_TYPE_OP, instruction[5:0]
        localparam logic [FUNCT_W-1:0] JR_FN   = 6'b001000;
        localparam logic [FUNCT_W-1:0] ADD_FN  = 6'b100000;
        localparam logic [FUNCT_W-1:0] ADDU_FN = 6'b100001;
        localparam logic [FUNCT_W-1:0] SUB_FN  = 6'b100010;
        localparam logic [FUNCT_W-1:0] SUBU_FN = 6'b100011;
        localparam logic [FUNCT_W-1:0] AND_FN  = 6'b100100;
        localparam logic [FUNCT_W-1:0] OR_FN   = 6'b100101;
        localparam logic [FUNCT_W-1:0] XOR_FN  = 6'b100110;
        localparam logic [FUNCT_W-1:0] NOR_FN  = 6'b100111;
        localparam logic [FUNCT_W-1:0] SLT_FN  = 6'b101010;
        localparam logic [FUNCT_W-1:0] SLTU_FN = 6'b101011;

        typedef enum logic [3:0] {
                ALU_ADD  = 4'b0000,
                ALU_SUB  = 4'b0001,
                ALU_AND  = 4'b0010,
                ALU_OR   = 4'b0011,
                ALU_XOR  = 4'b0100,
                ALU_NOR  = 4'b0101,
                ALU_SLT  = 4'b1001, // also serves the bgez test
                ALU_GTZ  = 4'b1010,
                ALU_LUI  = 4'b1011,
                ALU_LINK = 4'b1100  // return address for jal
        } alu_op_t;

        // second operand of the alu
        typedef enum logic [2:0] {
                SRC_REG   = 3'b000,
                SRC_LINK  = 3'b011,
                SRC_IMM   = 3'b100,
                SRC_UPPER = 3'b101  // imm16 shifted to the upper half
        } src_sel_t;

        typedef enum logic [1:0] {
                SIZE_BYTE = 2'b00,
                SIZE_HALF = 2'b01,
                SIZE_WORD = 2'b10
        } mem_size_t;

endpackage

/* decode/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder import decode_pkg::*; (
        input  logic [INSTR_W-1:0] instruction,
        output logic               alu_hit,
        output src_sel_t           src_sel,
        output alu_op_t            alu_op,
        output logic               rf_enable,
        output logic               dest_rd
);

        logic [OPCODE_W-1:0] opcode;
        logic [FUNCT_W-1:0]  funct;

        assign opcode = instruction[31:26];
        assign funct  = instruction[5:0];

        always_comb begin
                alu_hit   = 1'b1;
                src_sel   = SRC_REG;
                alu_op    = ALU_ADD;
                rf_enable = 1'b0;
                dest_rd   = 1'b0;

                case (opcode)
                R_TYPE_OP: begin
                        case (funct)
                        ADD_FN, ADDU_FN, JR_FN: alu_op = ALU_ADD;
                        SUB_FN, SUBU_FN:        alu_op = ALU_SUB;
                        AND_FN:                 alu_op = ALU_AND;
                        OR_FN:                  alu_op = ALU_OR;
                        XOR_FN:                 alu_op = ALU_XOR;
                        NOR_FN:                 alu_op = ALU_NOR;
                        SLT_FN, SLTU_FN:        alu_op = ALU_SLT;
                        default:                alu_hit = 1'b0; // shifts etc not decoded
                        endcase
                        rf_enable = alu_hit && (funct != JR_FN); // jr writes nothing
                        dest_rd   = rf_enable;                   // result goes to rd
                end
                ADDI_OP, ADDIU_OP, SLTI_OP, ANDI_OP, ORI_OP, XORI_OP: begin
                        src_sel   = SRC_IMM;
                        rf_enable = 1'b1; // result to rt
                        case (opcode)
                        SLTI_OP: alu_op = ALU_SLT;
                        ANDI_OP: alu_op = ALU_AND;
                        ORI_OP:  alu_op = ALU_OR;
                        XORI_OP: alu_op = ALU_XOR;
                        default: alu_op = ALU_ADD; // addi, addiu
                        endcase
                end
                LUI_OP: begin
                        src_sel   = SRC_UPPER;
                        alu_op    = ALU_LUI;
                        rf_enable = 1'b1;
                end
                LB_OP, LBU_OP, LH_OP, LHU_OP, LW_OP: begin
                        src_sel   = SRC_IMM; // base + offset
                        rf_enable = 1'b1;
                end
                SB_OP, SH_OP, SW_OP: src_sel = SRC_IMM;
                BGTZ_OP:             alu_op = ALU_GTZ;
                BGEZ_OP:             alu_op = ALU_SLT; // sign test on rs
                B_OP:                alu_op = ALU_ADD;
                JAL_OP: begin
                        src_sel   = SRC_LINK;
                        alu_op    = ALU_LINK;
                        rf_enable = 1'b1; // r31 gets pc+8
                end
                default: alu_hit = 1'b0;
                endcase
        end

endmodule

/* decode/flow_decoder.sv */
`timescale 1ns/1ps

module flow_decoder import decode_pkg::*; (
        input  logic [INSTR_W-1:0] instruction,
        output logic               flow_hit,
        output logic               load_instr,
        output logic               mem_enable,
        output logic               mem_rw,
        output logic               mem_se,
        output mem_size_t          mem_size,
        output logic               branch,
        output logic               target_addr,
        output logic               jump,
        output logic               link_r31
);

        logic [OPCODE_W-1:0] opcode;
        logic [FUNCT_W-1:0]  funct;

        assign opcode = instruction[31:26];
        assign funct  = instruction[5:0];

        always_comb begin
                flow_hit    = 1'b1;
                load_instr  = 1'b0;
                mem_enable  = 1'b0;
                mem_rw      = 1'b0;
                mem_se      = 1'b0;
                mem_size    = SIZE_BYTE;
                branch      = 1'b0;
                target_addr = 1'b0;
                jump        = 1'b0;
                link_r31    = 1'b0;

                case (opcode)
                R_TYPE_OP: begin
                        case (funct)
                        JR_FN: jump = 1'b1; // target from rs
                        ADD_FN, ADDU_FN, SUB_FN, SUBU_FN, AND_FN,
                        OR_FN, XOR_FN, NOR_FN, SLT_FN, SLTU_FN: flow_hit = 1'b1;
                        default: flow_hit = 1'b0;
                        endcase
                end
                // alu only, no flow fields
                ADDI_OP, ADDIU_OP, SLTI_OP, ANDI_OP, ORI_OP, XORI_OP, LUI_OP: flow_hit = 1'b1;
                LB_OP, LBU_OP: begin
                        load_instr = 1'b1;
                        mem_enable = 1'b1;
                        mem_se     = (opcode == LB_OP);
                end
                LH_OP, LHU_OP: begin
                        load_instr = 1'b1;
                        mem_enable = 1'b1;
                        mem_se     = (opcode == LH_OP);
                        mem_size   = SIZE_HALF;
                end
                LW_OP: begin
                        load_instr = 1'b1;
                        mem_enable = 1'b1;
                        mem_size   = SIZE_WORD;
                end
                SB_OP: begin
                        mem_rw     = 1'b1; // write
                        mem_enable = 1'b1;
                end
                SH_OP: begin
                        mem_rw     = 1'b1;
                        mem_enable = 1'b1;
                        mem_size   = SIZE_HALF;
                end
                SW_OP: begin
                        mem_rw     = 1'b1;
                        mem_enable = 1'b1;
                        mem_size   = SIZE_WORD;
                end
                B_OP, BGEZ_OP, BGTZ_OP: begin
                        branch      = 1'b1;
                        target_addr = 1'b1; // pc relative target
                end
                JAL_OP: begin
                        jump        = 1'b1;
                        target_addr = 1'b1;
                        link_r31    = 1'b1;
                end
                default: flow_hit = 1'b0;
                endcase
        end

endmodule

/* testbench/control_unit_properties.sv */
`timescale 1ns/1ps

module control_unit_properties import decode_pkg::*; (
        input logic      clk,
        input logic      reset,
        input logic      ctrl_valid,
        input src_sel_t  src_sel,
        input alu_op_t   alu_op,
        input logic      rf_enable,
        input logic      dest_rd,
        input logic      load_instr,
        input logic      mem_enable,
        input logic      mem_rw,
        input logic      mem_se,
        input mem_size_t mem_size,
        input logic      branch,
        input logic      target_addr,
        input logic      jump,
        input logic      link_r31
);

        int assert_errors = 0; // read by the testbench at the end

        logic [18:0] fields;

        assign fields = {src_sel, alu_op, rf_enable, dest_rd, load_instr, mem_enable, mem_rw,
                         mem_se, mem_size, branch, target_addr, jump, link_r31};

        assert property (@(posedge clk) reset |=> !ctrl_valid)
                else begin
                        $error("ctrl_valid high on the cycle after reset");
                        assert_errors = assert_errors + 1;
                end

        assert property (@(posedge clk) disable iff (reset) mem_rw |-> mem_enable)
                else begin
                        $error("memory write without mem_enable");
                        assert_errors = assert_errors + 1;
                end

        // stores write no register
        assert property (@(posedge clk) disable iff (reset) mem_rw |-> !rf_enable)
                else begin
                        $error("store with rf_enable set");
                        assert_errors = assert_errors + 1;
                end

        assert property (@(posedge clk) disable iff (reset) !ctrl_valid |-> (fields == '0))
                else begin
                        $error("control fields nonzero while ctrl_valid is low");
                        assert_errors = assert_errors + 1;
                end

endmodule

bind control_unit control_unit_properties i_control_unit_properties (.*);

/* testbench/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb import decode_pkg::*; ();

        localparam string STIM_FILE = "testbench/decode_stimulus.txt";
        localparam int    BLOCK_LEN = 6;           // vectors between idle gaps
        localparam int    SEED      = 32'h7a3165d2;

        typedef struct packed {
                logic               valid;
                logic [INSTR_W-1:0] instr;
                src_sel_t           src_sel;
                alu_op_t            alu_op;
                logic               rf_enable;
                logic               dest_rd;
                logic               load_instr;
                logic               mem_enable;
                logic               mem_rw;
                logic               mem_se;
                mem_size_t          mem_size;
                logic               branch;
                logic               target_addr;
                logic               jump;
                logic               link_r31;
        } vector_t;

        logic               clk;
        logic               reset;
        logic               instr_valid;
        logic [INSTR_W-1:0] instruction;
        logic               ctrl_valid;
        src_sel_t           src_sel;
        alu_op_t            alu_op;
        logic               rf_enable;
        logic               dest_rd;
        logic               load_instr;
        logic               mem_enable;
        logic               mem_rw;
        logic               mem_se;
        mem_size_t          mem_size;
        logic               branch;
        logic               target_addr;
        logic               jump;
        logic               link_r31;

        vector_t            vectors[$];
        vector_t            pending[$];    // one entry in flight through the register
        logic [INSTR_W-1:0] checked_instr;
        int                 cycle_count = 0;
        int                 cycle_limit = 0;
        int                 gap;

        control_unit i_control_unit (.*);

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        task automatic end_with_failure();
                $display("TEST FAIL");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] exp,
                                       input logic [31:0] got);
                $display("error %s expected %h got %h (instruction %h)", name, exp, got,
                         checked_instr);
                end_with_failure();
        endtask

        task automatic check_valid(input logic exp_ctrl_valid);
                if (ctrl_valid !== exp_ctrl_valid)
                        report_mismatch("ctrl_valid", 32'(exp_ctrl_valid), 32'(ctrl_valid));
        endtask

        task automatic check_alu_fields(input src_sel_t exp_src_sel, input alu_op_t exp_alu_op,
                                        input logic exp_rf_enable, input logic exp_dest_rd);
                if (src_sel !== exp_src_sel)
                        report_mismatch("src_sel", 32'(exp_src_sel), 32'(src_sel));
                if (alu_op !== exp_alu_op)
                        report_mismatch("alu_op", 32'(exp_alu_op), 32'(alu_op));
                if (rf_enable !== exp_rf_enable)
                        report_mismatch("rf_enable", 32'(exp_rf_enable), 32'(rf_enable));
                if (dest_rd !== exp_dest_rd)
                        report_mismatch("dest_rd", 32'(exp_dest_rd), 32'(dest_rd));
        endtask

        task automatic check_flow_fields(input logic exp_load_instr, input logic exp_mem_enable,
                                         input logic exp_mem_rw, input logic exp_mem_se,
                                         input mem_size_t exp_mem_size, input logic exp_branch,
                                         input logic exp_target_addr, input logic exp_jump,
                                         input logic exp_link_r31);
                if (load_instr !== exp_load_instr)
                        report_mismatch("load_instr", 32'(exp_load_instr), 32'(load_instr));
                if (mem_enable !== exp_mem_enable)
                        report_mismatch("mem_enable", 32'(exp_mem_enable), 32'(mem_enable));
                if (mem_rw !== exp_mem_rw)
                        report_mismatch("mem_rw", 32'(exp_mem_rw), 32'(mem_rw));
                if (mem_se !== exp_mem_se)
                        report_mismatch("mem_se", 32'(exp_mem_se), 32'(mem_se));
                if (mem_size !== exp_mem_size)
                        report_mismatch("mem_size", 32'(exp_mem_size), 32'(mem_size));
                if (branch !== exp_branch)
                        report_mismatch("branch", 32'(exp_branch), 32'(branch));
                if (target_addr !== exp_target_addr)
                        report_mismatch("target_addr", 32'(exp_target_addr), 32'(target_addr));
                if (jump !== exp_jump)
                        report_mismatch("jump", 32'(exp_jump), 32'(jump));
                if (link_r31 !== exp_link_r31)
                        report_mismatch("link_r31", 32'(exp_link_r31), 32'(link_r31));
        endtask

        task automatic compare_outputs(input vector_t exp);
                check_valid(exp.valid);
                check_alu_fields(exp.src_sel, exp.alu_op, exp.rf_enable, exp.dest_rd);
                check_flow_fields(exp.load_instr, exp.mem_enable, exp.mem_rw, exp.mem_se,
                                  exp.mem_size, exp.branch, exp.target_addr, exp.jump,
                                  exp.link_r31);
        endtask

        // valid low, so every expected field is zero whatever the instruction
        function automatic vector_t idle_word(input logic [INSTR_W-1:0] instr);
                vector_t w;
                w       = '0;
                w.instr = instr;
                return w;
        endfunction

        task automatic load_vectors();
                int          fd;
                int          n;
                string       line;
                logic [31:0] col [15];
                vector_t     v;
                fd = $fopen(STIM_FILE, "r");
                if (fd == 0) begin
                        $display("could not open the stimulus file %s", STIM_FILE);
                        end_with_failure();
                end
                while ($fgets(line, fd) > 0) begin
                        if (line.len() > 1 && line.getc(0) != "#") begin
                                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                            col[0], col[1], col[2], col[3], col[4], col[5],
                                            col[6], col[7], col[8], col[9], col[10], col[11],
                                            col[12], col[13], col[14]);
                                if (n != 15) begin
                                        $display("stimulus line has %0d columns: %s", n, line);
                                        end_with_failure();
                                end
                                v.valid       = col[0][0];
                                v.instr       = col[1];
                                v.src_sel     = src_sel_t'(col[2][2:0]);
                                v.alu_op      = alu_op_t'(col[3][3:0]);
                                v.rf_enable   = col[4][0];
                                v.dest_rd     = col[5][0];
                                v.load_instr  = col[6][0];
                                v.mem_enable  = col[7][0];
                                v.mem_rw      = col[8][0];
                                v.mem_se      = col[9][0];
                                v.mem_size    = mem_size_t'(col[10][1:0]);
                                v.branch      = col[11][0];
                                v.target_addr = col[12][0];
                                v.jump        = col[13][0];
                                v.link_r31    = col[14][0];
                                vectors.push_back(v);
                        end
                end
                $fclose(fd);
                if (vectors.size() == 0) begin
                        $display("the stimulus file holds no vectors");
                        end_with_failure();
                end
        endtask

        // drive one input, check the word captured on this same edge
        task automatic apply_vector(input vector_t v);
                vector_t exp;
                @(posedge clk);
                instr_valid <= v.valid;
                instruction <= v.instr;
                pending.push_back(v);
                exp = pending.pop_front();
                @(negedge clk);
                checked_instr = exp.instr;
                compare_outputs(exp);
        endtask

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                        $display("timeout, the run took more than %0d cycles", cycle_limit);
                        end_with_failure();
                end
        end

        initial begin
                reset       = 1'b1;
                instr_valid = 1'b0;
                instruction = '0;
                void'($urandom(SEED));
                load_vectors();
                cycle_limit = 2 * vectors.size() + 40;

                for (int i = 0; i < 4; i++) begin
                        @(posedge clk);
                        if (i == 3)
                                reset <= 1'b0;
                        @(negedge clk);
                        checked_instr = '0;
                        compare_outputs(idle_word('0)); // register held at zero
                end

                pending.push_back(idle_word('0)); // first edge after reset sees valid low
                for (int k = 0; k < vectors.size(); k++) begin
                        apply_vector(vectors[k]);
                        if ((k + 1) % BLOCK_LEN == 0) begin
                                gap = $urandom_range(2, 0);
                                repeat (gap) apply_vector(idle_word($urandom()));
                        end
                end
                apply_vector(idle_word('0)); // flush the last vector out

                if (i_control_unit.i_control_unit_properties.assert_errors == 0) begin
                        $display("TEST PASS");
                        $finish;
                end else begin
                        $display("%0d assertion failures during the run",
                                 i_control_unit.i_control_unit_properties.assert_errors);
                        end_with_failure();
                end
        end

endmodule

/* testbench/decode_stimulus.txt */
# valid instruction src_sel alu_op rf_enable dest_rd load_instr mem_enable mem_rw mem_se
# mem_size branch target_addr jump link_r31, all hex, fields expected one cycle later
1 00221820 0 0 1 1 0 0 0 0 0 0 0 0 0
1 00221821 0 0 1 1 0 0 0 0 0 0 0 0 0
1 00221822 0 1 1 1 0 0 0 0 0 0 0 0 0
1 00221823 0 1 1 1 0 0 0 0 0 0 0 0 0
1 00221824 0 2 1 1 0 0 0 0 0 0 0 0 0
1 00221825 0 3 1 1 0 0 0 0 0 0 0 0 0
0 00221820 0 0 0 0 0 0 0 0 0 0 0 0 0
1 00221826 0 4 1 1 0 0 0 0 0 0 0 0 0
1 00221827 0 5 1 1 0 0 0 0 0 0 0 0 0
1 0022182a 0 9 1 1 0 0 0 0 0 0 0 0 0
1 0022182b 0 9 1 1 0 0 0 0 0 0 0 0 0
1 20221234 4 0 1 0 0 0 0 0 0 0 0 0 0
1 24221234 4 0 1 0 0 0 0 0 0 0 0 0 0
1 28221234 4 9 1 0 0 0 0 0 0 0 0 0 0
1 30221234 4 2 1 0 0 0 0 0 0 0 0 0 0
1 34221234 4 3 1 0 0 0 0 0 0 0 0 0 0
1 38221234 4 4 1 0 0 0 0 0 0 0 0 0 0
1 3c02abcd 5 b 1 0 0 0 0 0 0 0 0 0 0
1 80220010 4 0 1 0 1 1 0 1 0 0 0 0 0
1 90220010 4 0 1 0 1 1 0 0 0 0 0 0 0
1 84220010 4 0 1 0 1 1 0 1 1 0 0 0 0
1 94220010 4 0 1 0 1 1 0 0 1 0 0 0 0
1 8c220010 4 0 1 0 1 1 0 0 2 0 0 0 0
1 a0220010 4 0 0 0 0 1 1 0 0 0 0 0 0
1 a4220010 4 0 0 0 0 1 1 0 1 0 0 0 0
1 ac220010 4 0 0 0 0 1 1 0 2 0 0 0 0
0 ac220010 0 0 0 0 0 0 0 0 0 0 0 0 0
1 10000004 0 0 0 0 0 0 0 0 0 1 1 0 0
1 04210008 0 9 0 0 0 0 0 0 0 1 1 0 0
1 1c20000c 0 a 0 0 0 0 0 0 0 1 1 0 0
1 0c000100 3 c 1 0 0 0 0 0 0 0 1 1 1
1 03e00008 0 0 0 0 0 0 0 0 0 0 0 1 0
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0
1 fc000000 0 0 0 0 0 0 0 0 0 0 0 0 0
1 08000040 0 0 0 0 0 0 0 0 0 0 0 0 0
1 00021080 0 0 0 0 0 0 0 0 0 0 0 0 0
1 00021082 0 0 0 0 0 0 0 0 0 0 0 0 0
1 00220018 0 0 0 0 0 0 0 0 0 0 0 0 0
1 2c221234 0 0 0 0 0 0 0 0 0 0 0 0 0
1 14220004 0 0 0 0 0 0 0 0 0 0 0 0 0

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit import decode_pkg::*; (
        input  logic               clk,
        input  logic               reset,
        input  logic               instr_valid,
        input  logic [INSTR_W-1:0] instruction,
        output logic               ctrl_valid,
        output src_sel_t           src_sel,
        output alu_op_t            alu_op,
        output logic               rf_enable,
        output logic               dest_rd,
        output logic               load_instr,
        output logic               mem_enable,
        output logic               mem_rw,
        output logic               mem_se,
        output mem_size_t          mem_size,
        output logic               branch,
        output logic               target_addr,
        output logic               jump,
        output logic               link_r31
);

        logic      alu_hit;
        logic      flow_hit;
        src_sel_t  dec_src_sel;
        alu_op_t   dec_alu_op;
        logic      dec_rf_enable;
        logic      dec_dest_rd;
        logic      dec_load_instr;
        logic      dec_mem_enable;
        logic      dec_mem_rw;
        logic      dec_mem_se;
        mem_size_t dec_mem_size;
        logic      dec_branch;
        logic      dec_target_addr;
        logic      dec_jump;
        logic      dec_link_r31;

        // both decoders look at the same instruction in the same cycle
        alu_decoder i_alu_decoder (
                .instruction (instruction),
                .alu_hit     (alu_hit),
                .src_sel     (dec_src_sel),
                .alu_op      (dec_alu_op),
                .rf_enable   (dec_rf_enable),
                .dest_rd     (dec_dest_rd)
        );

        flow_decoder i_flow_decoder (
                .instruction (instruction),
                .flow_hit    (flow_hit),
                .load_instr  (dec_load_instr),
                .mem_enable  (dec_mem_enable),
                .mem_rw      (dec_mem_rw),
                .mem_se      (dec_mem_se),
                .mem_size    (dec_mem_size),
                .branch      (dec_branch),
                .target_addr (dec_target_addr),
                .jump        (dec_jump),
                .link_r31    (dec_link_r31)
        );

        control_word_register i_control_word_register (
                .clk             (clk),
                .reset           (reset),
                .instr_valid     (instr_valid),
                .instruction     (instruction),
                .alu_hit         (alu_hit),
                .flow_hit        (flow_hit),
                .dec_src_sel     (dec_src_sel),
                .dec_alu_op      (dec_alu_op),
                .dec_rf_enable   (dec_rf_enable),
                .dec_dest_rd     (dec_dest_rd),
                .dec_load_instr  (dec_load_instr),
                .dec_mem_enable  (dec_mem_enable),
                .dec_mem_rw      (dec_mem_rw),
                .dec_mem_se      (dec_mem_se),
                .dec_mem_size    (dec_mem_size),
                .dec_branch      (dec_branch),
                .dec_target_addr (dec_target_addr),
                .dec_jump        (dec_jump),
                .dec_link_r31    (dec_link_r31),
                .ctrl_valid      (ctrl_valid),
                .src_sel         (src_sel),
                .alu_op          (alu_op),
                .rf_enable       (rf_enable),
                .dest_rd         (dest_rd),
                .load_instr      (load_instr),
                .mem_enable      (mem_enable),
                .mem_rw          (mem_rw),
                .mem_se          (mem_se),
                .mem_size        (mem_size),
                .branch          (branch),
                .target_addr     (target_addr),
                .jump            (jump),
                .link_r31        (link_r31)
        );

endmodule

/* verilog/control_word_register.sv */
`timescale 1ns/1ps

module control_word_register import decode_pkg::*; (
        input  logic               clk,
        input  logic               reset,
        input  logic               instr_valid,
        input  logic [INSTR_W-1:0] instruction,
        input  logic               alu_hit,
        input  logic               flow_hit,
        input  src_sel_t           dec_src_sel,
        input  alu_op_t            dec_alu_op,
        input  logic               dec_rf_enable,
        input  logic               dec_dest_rd,
        input  logic               dec_load_instr,
        input  logic               dec_mem_enable,
        input  logic               dec_mem_rw,
        input  logic               dec_mem_se,
        input  mem_size_t          dec_mem_size,
        input  logic               dec_branch,
        input  logic               dec_target_addr,
        input  logic               dec_jump,
        input  logic               dec_link_r31,
        output logic               ctrl_valid,
        output src_sel_t           src_sel,
        output alu_op_t            alu_op,
        output logic               rf_enable,
        output logic               dest_rd,
        output logic               load_instr,
        output logic               mem_enable,
        output logic               mem_rw,
        output logic               mem_se,
        output mem_size_t          mem_size,
        output logic               branch,
        output logic               target_addr,
        output logic               jump,
        output logic               link_r31
);

        logic keep; // word survives the squash rules

        assign keep = instr_valid && (instruction != '0) && (alu_hit || flow_hit);

        always_ff @(posedge clk) begin
                if (reset)
                        ctrl_valid <= 1'b0;
                else
                        ctrl_valid <= instr_valid; // squashed words still count as valid
        end

        always_ff @(posedge clk) begin
                if (reset || !keep) begin
                        src_sel     <= SRC_REG;
                        alu_op      <= ALU_ADD;
                        rf_enable   <= 1'b0;
                        dest_rd     <= 1'b0;
                        load_instr  <= 1'b0;
                        mem_enable  <= 1'b0;
                        mem_rw      <= 1'b0;
                        mem_se      <= 1'b0;
                        mem_size    <= SIZE_BYTE;
                        branch      <= 1'b0;
                        target_addr <= 1'b0;
                        jump        <= 1'b0;
                        link_r31    <= 1'b0;
                end else begin
                        src_sel     <= dec_src_sel;
                        alu_op      <= dec_alu_op;
                        rf_enable   <= dec_rf_enable;
                        dest_rd     <= dec_dest_rd;
                        load_instr  <= dec_load_instr;
                        mem_enable  <= dec_mem_enable;
                        mem_rw      <= dec_mem_rw;
                        mem_se      <= dec_mem_se;
                        mem_size    <= dec_mem_size;
                        branch      <= dec_branch;
                        target_addr <= dec_target_addr;
                        jump        <= dec_jump;
                        link_r31    <= dec_link_r31;
                end
        end

endmodule

/* vlog.f */
common/decode_pkg.sv
decode/alu_decoder.sv
decode/flow_decoder.sv
verilog/control_word_register.sv
verilog/control_unit.sv
testbench/control_unit_properties.sv
testbench/control_unit_tb.sv
